/* src/cpu_isa_pkg.sv */
//////////////////////////////////////////////////////////////////////
// Instruction set of the 16-bit teaching CPU
// Opcodes 12 to 15 are not encoded and must be treated as illegal
// Field positions assume a fixed 16-bit instruction word
//////////////////////////////////////////////////////////////////////
`default_nettype none

package cpu_isa_pkg;

  // Opcode encodings, bits 15..12 of the instruction
  typedef enum logic [3:0] {
    ADD    = 4'h0,  // Saturating add
    SUB    = 4'h1,  // Saturating subtract
    XOR    = 4'h2,
    RED    = 4'h3,  // Reduction of nibbles
    SLL    = 4'h4,
    SRA    = 4'h5,
    ROR    = 4'h6,
    PADDSB = 4'h7,  // Per-nibble saturating add
    LW     = 4'h8,  // Address only in this slice
    SW     = 4'h9,  // Address only in this slice
    LLB    = 4'hA,
    LHB    = 4'hB
  } opcode_e;

  // Instruction field positions
  localparam int OP_MSB   = 15;
  localparam int OP_LSB   = 12;
  localparam int RD_MSB   = 11;
  localparam int RD_LSB   = 8;
  localparam int RS_MSB   = 7;
  localparam int RS_LSB   = 4;
  localparam int RT_MSB   = 3;   // Also the 4-bit immediate
  localparam int RT_LSB   = 0;
  localparam int IMM8_MSB = 7;   // Overlaps rs and rt
  localparam int IMM8_LSB = 0;

  // Arithmetic ops load all three flags
  function automatic logic updates_znv(opcode_e op);
    return (op == ADD) || (op == SUB);
  endfunction

  // Logic and shift ops touch Z only
  function automatic logic updates_z_only(opcode_e op);
    return (op == XOR) || (op == SLL) || (op == SRA) || (op == ROR);
  endfunction

endpackage

`default_nettype wire

/* src/cpu_exec_pkg.sv */
//////////////////////////////////////////////////////////////////////
// Datapath sizes and types of the execute slice
// Register index width must cover REG_N entries
//////////////////////////////////////////////////////////////////////
`default_nettype none

package cpu_exec_pkg;

  localparam int DATA_W = 16;  // Data word width
  localparam int REG_N  = 16;  // Register count, r0 reads zero
  localparam int REG_AW = 4;   // Register index width

  typedef logic [DATA_W-1:0] word_t;
  typedef logic [REG_AW-1:0] reg_idx_t;

  // Condition flags, packed in z/v/n order from MSB
  typedef struct packed {
    logic z;  // Zero
    logic v;  // Signed overflow
    logic n;  // Negative
  } flags_t;

endpackage

`default_nettype wire

/* src/alu_op_if.sv */
//////////////////////////////////////////////////////////////////////
// Operation bundle between the execute stage and the ALU
// All signals are combinational within one cycle
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

interface alu_op_if;
  import cpu_isa_pkg::*;
  import cpu_exec_pkg::*;

  opcode_e op;      // Decoded opcode
  word_t   a;       // A operand
  word_t   b;       // B operand
  word_t   result;  // ALU result, zero on error
  flags_t  set;     // Flag values the op would load
  logic    error;   // Opcode not implemented

  // Execute side issues the operation
  modport exec (
    output op, a, b,
    input  result, set, error
  );

  // ALU side computes and answers
  modport alu (
    input  op, a, b,
    output result, set, error
  );

endinterface

`default_nettype wire

/* src/shifter.sv */
//////////////////////////////////////////////////////////////////////
// Log shifter, four stages of 1, 2, 4 and 8 places
// Mode 0 SLL, 1 SRA, 2 ROR, 3 passes the input through
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module shifter (
  input  cpu_exec_pkg::word_t shift_in,
  input  logic [1:0]          mode,
  input  logic [3:0]          shift_val,
  output cpu_exec_pkg::word_t shift_out
);
  import cpu_exec_pkg::*;

  word_t stg [0:4];  // stg[0] is the input, stg[4] the result

  assign stg[0] = shift_in;

  // Stage i moves by 2**i places when shift_val[i] is set
  for (genvar i = 0; i < 4; i++) begin : g_stage
    localparam int SH = 1 << i;
    word_t moved;

    always_comb begin
      case (mode)
        2'd0:    moved = stg[i] << SH;                        // Zero fill
        2'd1:    moved = $signed(stg[i]) >>> SH;              // Sign fill
        2'd2:    moved = {stg[i][SH-1:0], stg[i][DATA_W-1:SH]};  // Wrap low bits up
        default: moved = stg[i];
      endcase
    end

    assign stg[i+1] = shift_val[i] ? moved : stg[i];
  end

  assign shift_out = stg[4];

endmodule

`default_nettype wire

/* src/psa_16bit.sv */
//////////////////////////////////////////////////////////////////////
// Parallel saturating add on four signed nibble lanes
// Lanes never carry into each other, range is -8 to 7
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module psa_16bit (
  input  cpu_exec_pkg::word_t a,
  input  cpu_exec_pkg::word_t b,
  output cpu_exec_pkg::word_t sum
);
  import cpu_exec_pkg::*;

  for (genvar l = 0; l < DATA_W / 4; l++) begin : g_lane
    logic [3:0] na;
    logic [3:0] nb;
    logic [3:0] ns;      // Raw lane sum, wraps
    logic       pos_ov;
    logic       neg_ov;

    assign na = a[4*l +: 4];
    assign nb = b[4*l +: 4];
    assign ns = na + nb;

    // Same signs in, other sign out
    assign pos_ov = ~na[3] & ~nb[3] &  ns[3];
    assign neg_ov =  na[3] &  nb[3] & ~ns[3];

    assign sum[4*l +: 4] = pos_ov ? 4'h7 :
                           neg_ov ? 4'h8 : ns;  // Clamp to lane limits
  end

endmodule

`default_nettype wire

/* src/alu.sv */
//////////////////////////////////////////////////////////////////////
// Combinational ALU of the execute slice
// LW/SW only form the word address, memory is outside this slice
// Opcodes 12 to 15 raise error and give a zero result
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module alu (
  alu_op_if.alu op_if
);
  import cpu_isa_pkg::*;
  import cpu_exec_pkg::*;

  logic              is_mem;     // LW or SW
  logic              is_arith;   // ADD or SUB
  word_t             in_a;
  word_t             in_b;
  word_t             sum_step;   // Unsaturated sum or difference
  logic              b_sign;     // Sign of the effective addend
  logic              pos_ov;
  logic              neg_ov;
  word_t             sum_out;
  logic signed [6:0] red_acc;    // Sum of eight signed nibbles
  word_t             red_out;
  word_t             shift_out;
  word_t             psa_out;
  word_t             llb_out;
  word_t             lhb_out;

  //////////////////////////////////////////////////////////////////////
  // Operand conditioning and adder
  //////////////////////////////////////////////////////////////////////
  assign is_mem   = (op_if.op == LW) || (op_if.op == SW);
  assign is_arith = (op_if.op == ADD) || (op_if.op == SUB);

  // Word aligned base, immediate scaled to bytes
  assign in_a = is_mem ? {op_if.a[DATA_W-1:1], 1'b0} : op_if.a;
  assign in_b = is_mem ? {op_if.b[DATA_W-2:0], 1'b0} : op_if.b;

  assign sum_step = (op_if.op == SUB) ? in_a - in_b : in_a + in_b;

  // SUB adds the negated B, so its sign flips
  assign b_sign = (op_if.op == SUB) ? ~in_b[DATA_W-1] : in_b[DATA_W-1];

  assign pos_ov = is_arith & ~in_a[DATA_W-1] & ~b_sign &  sum_step[DATA_W-1];
  assign neg_ov = is_arith &  in_a[DATA_W-1] &  b_sign & ~sum_step[DATA_W-1];

  // Addresses wrap, arithmetic clamps
  assign sum_out = pos_ov ? 16'h7FFF :
                   neg_ov ? 16'h8000 : sum_step;

  //////////////////////////////////////////////////////////////////////
  // RED, shifts, PADDSB and byte loads
  //////////////////////////////////////////////////////////////////////
  always_comb begin
    red_acc = '0;
    for (int i = 0; i < DATA_W / 4; i++) begin
      red_acc = red_acc + $signed(in_a[4*i +: 4]) + $signed(in_b[4*i +: 4]);
    end
  end

  assign red_out = {{(DATA_W-7){red_acc[6]}}, red_acc};  // Sign extend to a word

  // Low opcode bits map SLL/SRA/ROR onto shifter modes 0..2
  shifter shifter_i (
    .shift_in  (in_a),
    .mode      (op_if.op[1:0]),
    .shift_val (in_b[3:0]),
    .shift_out (shift_out)
  );

  psa_16bit psa_16bit_i (
    .a   (in_a),
    .b   (in_b),
    .sum (psa_out)
  );

  assign llb_out = {in_a[DATA_W-1:8], in_b[7:0]};  // Keep high byte
  assign lhb_out = {in_b[7:0], in_a[7:0]};         // Keep low byte

  //////////////////////////////////////////////////////////////////////
  // Result select and flag set bits
  //////////////////////////////////////////////////////////////////////
  always_comb begin
    op_if.error  = 1'b0;
    op_if.result = '0;
    case (op_if.op)
      ADD, SUB, LW, SW: op_if.result = sum_out;
      XOR:              op_if.result = in_a ^ in_b;
      RED:              op_if.result = red_out;
      SLL, SRA, ROR:    op_if.result = shift_out;
      PADDSB:           op_if.result = psa_out;
      LLB:              op_if.result = llb_out;
      LHB:              op_if.result = lhb_out;
      default:          op_if.error  = 1'b1;  // Result stays zero
    endcase
  end

  assign op_if.set.z = (op_if.result == '0);
  assign op_if.set.v = pos_ov | neg_ov;       // Only ADD/SUB can overflow
  assign op_if.set.n = op_if.result[DATA_W-1];

  // An unknown opcode must give a clean zero with no overflow
  always_comb begin
    assert final (!op_if.error || (op_if.result == '0 && !op_if.set.v))
      else $error("ALU error without zero result");
  end

endmodule

`default_nettype wire

/* src/reg_file.sv */
//////////////////////////////////////////////////////////////////////
// Register file, two combinational reads and one write per edge
// r0 reads zero and ignores writes
// A read in the cycle after a write sees the new value
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module reg_file (
  input  logic                   clk,
  input  logic                   arst_n,
  input  cpu_exec_pkg::reg_idx_t ra_idx,
  input  cpu_exec_pkg::reg_idx_t rb_idx,
  input  logic                   we,
  input  cpu_exec_pkg::reg_idx_t wa,
  input  cpu_exec_pkg::word_t    wd,
  output cpu_exec_pkg::word_t    ra_data,
  output cpu_exec_pkg::word_t    rb_data
);
  import cpu_exec_pkg::*;

  word_t regs [REG_N];

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      for (int i = 0; i < REG_N; i++) begin
        regs[i] <= '0;
      end
    end else if (we && wa != '0) begin  // r0 stays zero
      regs[wa] <= wd;
    end
  end

  // Read ports
  assign ra_data = (ra_idx == '0) ? '0 : regs[ra_idx];
  assign rb_data = (rb_idx == '0) ? '0 : regs[rb_idx];

  // The execute stage is expected to drop writes to r0 itself
  assert property (@(posedge clk) disable iff (!arst_n) we |-> wa != '0)
    else $error("Write enable raised for r0");

endmodule

`default_nettype wire

/* src/exec_stage.sv */
//////////////////////////////////////////////////////////////////////
// Decode, operand select, write-back and flag register
// One instruction per cycle, no back-pressure
// Outputs are valid the cycle after instr_valid
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module exec_stage (
  input  logic                   clk,
  input  logic                   arst_n,
  input  logic                   instr_valid,
  input  cpu_exec_pkg::word_t    instr,
  output cpu_exec_pkg::reg_idx_t ra_idx,
  output cpu_exec_pkg::reg_idx_t rb_idx,
  output logic                   we,
  output cpu_exec_pkg::reg_idx_t wa,
  output cpu_exec_pkg::word_t    wd,
  input  cpu_exec_pkg::word_t    ra_data,
  input  cpu_exec_pkg::word_t    rb_data,
  alu_op_if.exec                 op_if,
  output logic                   result_valid,
  output cpu_exec_pkg::word_t    result,
  output cpu_exec_pkg::flags_t   flags,
  output logic                   illegal
);
  import cpu_isa_pkg::*;
  import cpu_exec_pkg::*;

  opcode_e    opc;
  reg_idx_t   rd;
  reg_idx_t   rs;
  logic [3:0] imm4;   // Same bits as rt
  logic [7:0] imm8;
  word_t      b_sel;

  //////////////////////////////////////////////////////////////////////
  // Decode and operand select
  //////////////////////////////////////////////////////////////////////
  assign opc  = opcode_e'(instr[OP_MSB:OP_LSB]);
  assign rd   = instr[RD_MSB:RD_LSB];
  assign rs   = instr[RS_MSB:RS_LSB];
  assign imm4 = instr[RT_MSB:RT_LSB];
  assign imm8 = instr[IMM8_MSB:IMM8_LSB];

  assign ra_idx = (opc == LLB || opc == LHB) ? rd : rs;  // Byte loads modify rd
  assign rb_idx = imm4;

  always_comb begin
    case (opc)
      SLL, SRA, ROR: b_sel = {{(DATA_W-4){1'b0}}, imm4};     // Shift amount
      LW, SW:        b_sel = {{(DATA_W-4){imm4[3]}}, imm4};  // Signed word offset
      LLB, LHB:      b_sel = {{(DATA_W-8){1'b0}}, imm8};
      default:       b_sel = rb_data;
    endcase
  end

  assign op_if.op = opc;
  assign op_if.a  = ra_data;
  assign op_if.b  = b_sel;

  // Write-back at the issue edge, never for memory ops or r0
  assign we = instr_valid && !op_if.error && opc != LW && opc != SW && rd != '0;
  assign wa = rd;
  assign wd = op_if.result;

  //////////////////////////////////////////////////////////////////////
  // Flag register and output registers
  //////////////////////////////////////////////////////////////////////
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      flags        <= '0;
      result_valid <= 1'b0;
      illegal      <= 1'b0;
    end else begin
      result_valid <= instr_valid;
      illegal      <= instr_valid && op_if.error;  // One-cycle pulse
      if (instr_valid && updates_znv(opc)) begin
        flags <= op_if.set;
      end else if (instr_valid && updates_z_only(opc)) begin
        flags.z <= op_if.set.z;  // V and N hold
      end
    end
  end

  always_ff @(posedge clk) begin
    if (instr_valid) begin
      result <= op_if.result;
    end
  end

  // Fixed one-cycle latency
  assert property (@(posedge clk) disable iff (!arst_n)
                   result_valid == $past(instr_valid))
    else $error("result_valid does not follow instr_valid");

  // Illegal ops report a zero result through the ALU
  assert property (@(posedge clk) disable iff (!arst_n) illegal |-> result == '0)
    else $error("Illegal opcode with nonzero result");

endmodule

`default_nettype wire

/* src/cpu_exec_top.sv */
//////////////////////////////////////////////////////////////////////
// Execute slice top, register file plus execute stage plus ALU
// instr is sampled with instr_valid, results one cycle later
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module cpu_exec_top (
  input  logic                                     clk,
  input  logic                                     arst_n,
  input  logic                                     instr_valid,
  input  logic [cpu_exec_pkg::DATA_W-1:0]          instr,
  output logic                                     result_valid,
  output logic [cpu_exec_pkg::DATA_W-1:0]          result,
  output logic [$bits(cpu_exec_pkg::flags_t)-1:0]  flags,  // {z, v, n}
  output logic                                     illegal
);
  import cpu_exec_pkg::*;

  reg_idx_t ra_idx;
  reg_idx_t rb_idx;
  logic     we;
  reg_idx_t wa;
  word_t    wd;
  word_t    ra_data;
  word_t    rb_data;

  alu_op_if alu_op_if_i ();  // Execute stage to ALU

  reg_file reg_file_i (
    .clk     (clk),
    .arst_n  (arst_n),
    .ra_idx  (ra_idx),
    .rb_idx  (rb_idx),
    .we      (we),
    .wa      (wa),
    .wd      (wd),
    .ra_data (ra_data),
    .rb_data (rb_data)
  );

  exec_stage exec_stage_i (
    .clk          (clk),
    .arst_n       (arst_n),
    .instr_valid  (instr_valid),
    .instr        (instr),
    .ra_idx       (ra_idx),
    .rb_idx       (rb_idx),
    .we           (we),
    .wa           (wa),
    .wd           (wd),
    .ra_data      (ra_data),
    .rb_data      (rb_data),
    .op_if        (alu_op_if_i.exec),
    .result_valid (result_valid),
    .result       (result),
    .flags        (flags),
    .illegal      (illegal)
  );

  alu alu_i (
    .op_if (alu_op_if_i.alu)
  );

endmodule

`default_nettype wire

/* verification/tb_alu_model.svh */
//////////////////////////////////////////////////////////////////////
// Reference model of the execute slice instructions
// Needs cpu_isa_pkg imported in the including scope
// Flags are packed {z, v, n}, register values are passed in by value
//////////////////////////////////////////////////////////////////////
`ifndef TB_ALU_MODEL_SVH
`define TB_ALU_MODEL_SVH

// Signed value of one nibble
function automatic int nibble_value(logic [3:0] x);
  return int'($signed(x));
endfunction

// Exact signed sum or difference, no clamping yet
function automatic int wide_sum(logic [15:0] a, logic [15:0] b, logic sub);
  return sub ? int'($signed(a)) - int'($signed(b)) : int'($signed(a)) + int'($signed(b));
endfunction

// Sum of all eight nibbles of a and b, sign extended by truncation
function automatic logic [15:0] red_sum(logic [15:0] a, logic [15:0] b);
  int acc;
  acc = 0;
  for (int i = 0; i < 4; i++) begin
    acc = acc + nibble_value(a[4*i +: 4]) + nibble_value(b[4*i +: 4]);
  end
  return 16'(acc);
endfunction

// Four independent lanes, each clamped to -8..7
function automatic logic [15:0] lane_sat_add(logic [15:0] a, logic [15:0] b);
  logic [15:0] res;
  int          s;
  for (int l = 0; l < 4; l++) begin
    s = nibble_value(a[4*l +: 4]) + nibble_value(b[4*l +: 4]);
    if (s > 7) s = 7;
    if (s < -8) s = -8;
    res[4*l +: 4] = 4'(s);
  end
  return res;
endfunction

function automatic logic [15:0] rotate_right(logic [15:0] a, logic [3:0] n);
  logic [31:0] d;
  d = {a, a} >> n;  // Low half is the rotated word
  return d[15:0];
endfunction

// Word aligned base plus byte offset of a signed word count
function automatic logic [15:0] word_address(logic [15:0] a, logic [3:0] imm);
  logic [15:0] off;
  off = {{12{imm[3]}}, imm};
  return (a & 16'hFFFE) + (off << 1);  // Wraps at 16 bits
endfunction

// Predicts one instruction from its operands and the current flags
task automatic predict_step(input logic [15:0] word, input logic [15:0] a_val,
                            input logic [15:0] rt_val, input logic [2:0] fl_in,
                            output logic [15:0] res, output logic [2:0] fl_out,
                            output logic ill, output logic wr);
  logic [3:0] op;
  int         s;
  logic       ov;
  op     = word[15:12];
  res    = '0;
  ill    = 1'b0;
  ov     = 1'b0;
  wr     = (word[11:8] != 4'd0);  // r0 never written
  fl_out = fl_in;
  case (op)
    ADD, SUB: begin
      s = wide_sum(a_val, rt_val, op == SUB);
      if (s > 32767) begin
        res = 16'h7FFF;
        ov  = 1'b1;
      end else if (s < -32768) begin
        res = 16'h8000;
        ov  = 1'b1;
      end else begin
        res = 16'(s);
      end
      fl_out = {res == 16'd0, ov, res[15]};  // All three flags load
    end
    XOR:     res = a_val ^ rt_val;
    RED:     res = red_sum(a_val, rt_val);
    SLL:     res = a_val << word[3:0];
    SRA:     res = 16'($signed(a_val) >>> word[3:0]);
    ROR:     res = rotate_right(a_val, word[3:0]);
    PADDSB:  res = lane_sat_add(a_val, rt_val);
    LW, SW: begin
      res = word_address(a_val, word[3:0]);
      wr  = 1'b0;  // Address only
    end
    LLB:     res = {a_val[15:8], word[7:0]};
    LHB:     res = {word[7:0], a_val[7:0]};
    default: begin
      ill = 1'b1;
      wr  = 1'b0;
    end
  endcase
  if (op == XOR || op == SLL || op == SRA || op == ROR) fl_out[2] = (res == 16'd0);  // Z only
endtask

`endif

/* verification/tb_cpu_exec.sv */
//////////////////////////////////////////////////////////////////////
// Testbench of the execute slice, checks every result against a model
// Stops at the first mismatch, expects one result per issued instruction
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module tb_cpu_exec;
  import cpu_isa_pkg::*;

  `include "tb_alu_model.svh"

  localparam int N_ARITH = 40;  // Random ADD/SUB
  localparam int N_REDP  = 32;  // Random RED/PADDSB
  localparam int N_ISSUE = 47 + 12 + N_ARITH + 61 + N_REDP + 32 + 32;  // Whole run

  logic        clk;
  logic        arst_n;
  logic        instr_valid;
  logic [15:0] instr;
  logic        result_valid;
  logic [15:0] result;
  logic [2:0]  flags;         // {z, v, n}
  logic        illegal;

  integer      seed = 32'h7b00_fa9e;
  logic [15:0] shadow_regs [16];
  logic [2:0]  shadow_flags;
  logic [15:0] pend_result;   // Prediction of the instruction on the bus
  logic [2:0]  pend_flags;
  logic        pend_illegal;
  string       pend_name;
  logic [15:0] exp_result;    // Prediction aligned with result_valid
  logic [2:0]  exp_flags;
  logic        exp_illegal;
  string       exp_name;
  string       shown_name;    // exp_name as it was before the edge
  int          issued       = 0;
  int          results_seen = 0;

  cpu_exec_top cpu_exec_top_i (
    .clk          (clk),
    .arst_n       (arst_n),
    .instr_valid  (instr_valid),
    .instr        (instr),
    .result_valid (result_valid),
    .result       (result),
    .flags        (flags),
    .illegal      (illegal)
  );

  initial clk = 1'b0;
  always #50 clk = ~clk;  // 100 ns period

  //////////////////////////////////////////////////////////////////////
  // Expected values, checks and failure reports
  //////////////////////////////////////////////////////////////////////
  always @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      exp_result  <= '0;
      exp_flags   <= '0;
      exp_illegal <= 1'b0;
    end else if (instr_valid) begin  // Same edge as the DUT registers
      exp_result  <= pend_result;
      exp_flags   <= pend_flags;
      exp_illegal <= pend_illegal;
      exp_name    <= pend_name;
    end
  end

  always @(posedge clk) begin
    shown_name <= exp_name;
    if (arst_n && result_valid) results_seen <= results_seen + 1;
  end

  task automatic report_mismatch(string what, logic [15:0] expected, logic [15:0] actual);
    $display("Fail %s: expected %h, actual %h", what, expected, actual);
    $display("Simulation FAILED");
    $fatal(1, "Mismatch in %s", what);
  endtask

  task automatic report_failure(string msg);
    $display("%s", msg);
    $display("Simulation FAILED");
    $fatal(1, "%s", msg);
  endtask

  assert property (@(posedge clk) disable iff (!arst_n) result_valid |-> result == exp_result)
    else report_mismatch({shown_name, " result"}, $sampled(exp_result), $sampled(result));

  assert property (@(posedge clk) disable iff (!arst_n) result_valid |-> flags == exp_flags)
    else report_mismatch({shown_name, " flags"}, $sampled(exp_flags), $sampled(flags));

  // Pulse only with a result, and only for opcodes 12 to 15
  assert property (@(posedge clk) disable iff (!arst_n)
                   result_valid ? illegal == exp_illegal : !illegal)
    else report_mismatch({shown_name, " illegal"}, $sampled(exp_illegal), $sampled(illegal));

  assert property (@(posedge clk) disable iff (!arst_n) result_valid == $past(instr_valid))
    else report_failure("result_valid did not follow instr_valid by one cycle");

  initial begin
    #((N_ISSUE + 100) * 100);
    report_failure("Timeout, the test sequence did not finish in time");
  end

  //////////////////////////////////////////////////////////////////////
  // Stimulus helpers
  //////////////////////////////////////////////////////////////////////
  function automatic logic [15:0] enc(logic [3:0] op, logic [3:0] rd, logic [3:0] rs,
                                      logic [3:0] rt);
    return {op, rd, rs, rt};
  endfunction

  function automatic logic [15:0] enc8(logic [3:0] op, logic [3:0] rd, logic [7:0] imm);
    return {op, rd, imm};
  endfunction

  function automatic logic [3:0] nz_reg(int r);
    return 4'((r & 32'h7fff_ffff) % 15 + 1);  // r1..r15
  endfunction

  // Drives one instruction and advances the shadow state
  task automatic issue(logic [15:0] word, string name);
    logic [15:0] a_val;
    logic [15:0] res;
    logic [2:0]  fl;
    logic        ill;
    logic        wr;
    @(posedge clk);
    #5;
    instr_valid = 1'b1;
    instr       = word;
    a_val = (word[15:12] == LLB || word[15:12] == LHB) ? shadow_regs[word[11:8]]
                                                         : shadow_regs[word[7:4]];
    predict_step(word, a_val, shadow_regs[word[3:0]], shadow_flags, res, fl, ill, wr);
    pend_result  = res;
    pend_flags   = fl;
    pend_illegal = ill;
    pend_name    = name;
    if (wr) shadow_regs[word[11:8]] = res;
    shadow_flags = fl;
    issued++;
  endtask

  task automatic idle();
    @(posedge clk);
    #5;
    instr_valid = 1'b0;
  endtask

  task automatic load_word(logic [3:0] r, logic [15:0] w, string name);
    issue(enc8(LLB, r, w[7:0]), name);
    issue(enc8(LHB, r, w[15:8]), name);
  endtask

  // ADD rX, rX, r0 writes back the same value
  task automatic readback_all(string name);
    for (int r = 0; r < 16; r++) issue(enc(ADD, 4'(r), 4'(r), 4'd0), name);
  endtask

  //////////////////////////////////////////////////////////////////////
  // Test sequence
  //////////////////////////////////////////////////////////////////////
  initial begin
    logic [15:0] w;
    logic [3:0]  rs;
    logic [3:0]  rt;
    arst_n      = 1'b0;
    instr_valid = 1'b0;
    instr       = '0;
    shadow_flags = '0;
    for (int r = 0; r < 16; r++) shadow_regs[r] = '0;
    repeat (16) @(posedge clk);
    #5 arst_n = 1'b1;

    for (int r = 1; r < 16; r++) load_word(4'(r), 16'($random(seed)), "load");
    issue(enc8(LLB, 4'd0, 8'hA5), "load_r0");  // Must be dropped
    readback_all("load_readback");

    load_word(4'd1, 16'h7FF0, "addsub_setup");
    load_word(4'd2, 16'h0020, "addsub_setup");
    load_word(4'd4, 16'h8010, "addsub_setup");
    load_word(4'd5, 16'hFF00, "addsub_setup");
    issue(enc(ADD, 4'd3, 4'd1, 4'd2), "add_pos_sat");
    issue(enc(ADD, 4'd3, 4'd4, 4'd5), "add_neg_sat");
    issue(enc(SUB, 4'd3, 4'd1, 4'd4), "sub_pos_sat");
    issue(enc(SUB, 4'd3, 4'd4, 4'd1), "sub_neg_sat");
    for (int i = 0; i < N_ARITH; i++) begin
      rs = nz_reg($random(seed));
      rt = (i % 8 == 1) ? rs : nz_reg($random(seed));  // Some zero differences
      issue(enc((i % 2) ? SUB : ADD, 4'($random(seed)), rs, rt), "addsub_random");
    end

    load_word(4'd1, 16'h8010, "shift_setup");
    load_word(4'd2, 16'hFF00, "shift_setup");
    issue(enc(ADD, 4'd3, 4'd1, 4'd2), "shift_setup");  // V and N set, must hold below
    for (int n = 0; n < 16; n++) begin
      issue(enc(SLL, nz_reg($random(seed)), nz_reg($random(seed)), 4'(n)), "sll");
      issue(enc(SRA, nz_reg($random(seed)), nz_reg($random(seed)), 4'(n)), "sra");
      issue(enc(ROR, nz_reg($random(seed)), nz_reg($random(seed)), 4'(n)), "ror");
    end
    for (int i = 0; i < 8; i++) begin
      rs = nz_reg($random(seed));
      rt = (i == 0) ? rs : nz_reg($random(seed));  // Self XOR gives Z
      issue(enc(XOR, nz_reg($random(seed)), rs, rt), "xor");
    end

    for (int i = 0; i < N_REDP; i++) begin
      issue(enc((i % 2) ? PADDSB : RED, nz_reg($random(seed)), nz_reg($random(seed)),
                nz_reg($random(seed))), "red_paddsb");
    end

    for (int i = 0; i < 16; i++) begin
      issue(enc((i % 2) ? SW : LW, nz_reg($random(seed)), 4'($random(seed)),
                4'($random(seed))), "lw_sw_addr");
    end
    readback_all("lw_sw_readback");

    for (int op = 12; op < 16; op++) begin
      repeat (2) issue(enc(4'(op), nz_reg($random(seed)), 4'($random(seed)),
                           4'($random(seed))), "illegal");
    end
    w = 16'($random(seed));
    issue(enc8(LLB, 4'd9, w[7:0]), "chain");  // Each step reads the one before
    issue(enc8(LHB, 4'd9, w[15:8]), "chain");
    issue(enc(ADD, 4'd10, 4'd9, 4'd9), "chain");
    issue(enc(SUB, 4'd11, 4'd10, 4'd9), "chain");
    issue(enc(XOR, 4'd12, 4'd11, 4'd10), "chain");
    issue(enc(SLL, 4'd13, 4'd12, 4'd3), "chain");
    issue(enc(PADDSB, 4'd14, 4'd13, 4'd9), "chain");
    issue(enc(RED, 4'd15, 4'd14, 4'd13), "chain");
    readback_all("final_readback");

    idle();
    repeat (3) @(posedge clk);
    if (results_seen == issued) begin
      $display("Simulation PASSED");
      $finish;
    end else begin
      $display("Saw %0d results for %0d instructions", results_seen, issued);
      $display("Simulation FAILED");
      $fatal(1, "Result count does not match the issued count");
    end
  end

endmodule

`default_nettype wire

/* flist.f */
+incdir+verification
src/cpu_isa_pkg.sv
src/cpu_exec_pkg.sv
src/alu_op_if.sv
src/shifter.sv
src/psa_16bit.sv
src/alu.sv
src/reg_file.sv
src/exec_stage.sv
src/cpu_exec_top.sv
verification/tb_cpu_exec.sv

/* Bender.yml */
package:
  name: cpu_exec

sources:
  - files:
      - src/cpu_isa_pkg.sv
      - src/cpu_exec_pkg.sv
      - src/alu_op_if.sv
      - src/shifter.sv
      - src/psa_16bit.sv
      - src/alu.sv
      - src/reg_file.sv
      - src/exec_stage.sv
      - src/cpu_exec_top.sv
  - target: test
    include_dirs:
      - verification
    files:
      - verification/tb_cpu_exec.sv
